// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_read_interconnect -f sim.f

./obj_dir/Vtb_read_interconnect | tee sim.log

grep -q "Everything OK" sim.log

// ==== sim.f ====
verilog/axi_read_pkg.sv
verilog/read_arbiter.sv
verilog/ar_forward.sv
verilog/r_return.sv
verilog/decode_error_slave.sv
verilog/read_interconnect.sv
tests/tb_read_interconnect.sv

// ==== tests/tb_read_interconnect.sv ====
`timescale 1ns/1ps

module tb_read_interconnect;

    localparam int DW = 32;
    localparam int NM = axi_read_pkg::NUM_MASTERS;
    localparam int NS = axi_read_pkg::NUM_SLAVES;

    logic                                ACLK;
    logic                                ARESETn;
    axi_read_pkg::ar_req_t [NM-1:0]      m_ar;
    logic [NM-1:0]                       m_arvalid;
    logic [NM-1:0]                       m_arready;
    logic [NM-1:0][DW-1:0]               m_rdata;
    axi_read_pkg::r_ctrl_t [NM-1:0]      m_rctrl;
    logic [NM-1:0]                       m_rvalid;
    logic [NM-1:0]                       m_rready;
    logic                                m1_wvalid;
    axi_read_pkg::ar_req_t [NS-1:0]      s_ar;
    logic [NS-1:0]                       s_arvalid;
    logic [NS-1:0]                       s_arready;
    logic [NS-1:0][DW-1:0]               s_rdata;
    axi_read_pkg::r_ctrl_t [NS-1:0]      s_rctrl;
    logic [NS-1:0]                       s_rvalid;
    logic [NS-1:0]                       s_rready;

    // pending requests per master with the front one on the bus
    axi_read_pkg::ar_req_t req_q[NM][$];
    // expected beats of the burst in flight
    logic [DW-1:0]         exp_data_q[$];
    axi_read_pkg::r_ctrl_t exp_ctrl_q[$];
    int                    exp_owner;
    axi_read_pkg::master_t done_q[$];
    int                    issued[NM];
    int                    done_cnt[NM];
    // slave model state
    logic                  sl_busy[NS];
    axi_read_pkg::ar_req_t sl_ar[NS];
    int                    sl_beat[NS];
    logic                  stall_on;
    logic                  wv_random;
    string                 test_name;

    read_interconnect #(
        .DATA_WIDTH (DW)
    ) i_read_interconnect (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_rdata   (m_rdata),
        .m_rctrl   (m_rctrl),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready),
        .m1_wvalid (m1_wvalid),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rctrl   (s_rctrl),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready)
    );

    initial ACLK = 1'b0;
    always #4 ACLK = ~ACLK;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_master(input axi_read_pkg::master_t exp, input axi_read_pkg::master_t act);
        if (exp !== act) begin
            report_error($sformatf("mismatch %s: master expected %s actual %s",
                test_name, exp.name(), act.name()));
        end
    endtask

    task automatic check_data(input logic [DW-1:0] exp, input logic [DW-1:0] act);
        if (exp !== act) begin
            report_error($sformatf("mismatch %s: data expected %h actual %h",
                test_name, exp, act));
        end
    endtask

    task automatic check_ctrl(input axi_read_pkg::r_ctrl_t exp, input axi_read_pkg::r_ctrl_t act);
        if (exp !== act) begin
            report_error($sformatf("mismatch %s: resp/last expected %0d/%0d actual %0d/%0d",
                test_name, exp.resp, exp.last, act.resp, act.last));
        end
    endtask

    task automatic verify_ar(input axi_read_pkg::ar_req_t exp, input axi_read_pkg::ar_req_t act);
        if (exp !== act) begin
            report_error($sformatf("mismatch %s: slave AR expected %h/%0d actual %h/%0d",
                test_name, exp.addr, exp.len, act.addr, act.len));
        end
    endtask

    task automatic verify_target(input axi_read_pkg::slave_t exp, input axi_read_pkg::slave_t act);
        if (exp !== act) begin
            report_error($sformatf("mismatch %s: target expected %0d actual %0d",
                test_name, exp, act));
        end
    endtask

    // address map model where 8 means unmapped
    function automatic axi_read_pkg::slave_t expected_slave(input axi_read_pkg::addr_t a);
        if (a[31:24] == 8'h20) return 4'd5;
        case (a[31:16])
            16'h0000: return 4'd0;
            16'h0001: return 4'd1;
            16'h0002: return 4'd2;
            16'h1000: return 4'd3;
            16'h1001: return 4'd4;
            16'h0010: return 4'd6;
            16'h0003: return 4'd7;
            default:  return 4'd8;
        endcase
    endfunction

    // entries 0..7 follow the map and 8..11 are holes
    function automatic axi_read_pkg::addr_t region_addr(input int idx);
        logic [31:0] low;
        low = $urandom & 32'h0000_fffc;
        case (idx)
            0:       return 32'h0000_0000 | low;
            1:       return 32'h0001_0000 | low;
            2:       return 32'h0002_0000 | low;
            3:       return 32'h1000_0000 | low;
            4:       return 32'h1001_0000 | low;
            5:       return 32'h2000_0000 | ($urandom & 32'h00ff_fffc);
            6:       return 32'h0010_0000 | low;
            7:       return 32'h0003_0000 | low;
            8:       return 32'h0004_0000 | low;
            9:       return 32'h3000_0000 | low;
            10:      return 32'h1002_0000 | low;
            default: return 32'hffff_0000 | low;
        endcase
    endfunction

    task automatic issue(input int m, input int region);
        axi_read_pkg::ar_req_t r;
        r.addr = region_addr(region);
        r.len  = axi_read_pkg::len_t'($urandom_range(0, 15));
        req_q[m].push_back(r);
        issued[m]++;
    endtask

    task automatic check_quiet();
        if (m_arready !== '0 || m_rvalid !== '0 || s_arvalid !== '0 || s_rready !== '0) begin
            report_error($sformatf("%s: a ready or valid output is not low", test_name));
        end
    endtask

    // sampled mid-cycle where values match those seen at the next edge
    task automatic sample_and_check();
        axi_read_pkg::slave_t  tgt;
        axi_read_pkg::slave_t  act;
        axi_read_pkg::r_ctrl_t c;
        logic [DW-1:0]         d;
        int                    n_s;
        int                    n_m;
        logic                  hit;
        @(negedge ACLK);
        // R beats only at the owner of the grant
        for (int i = 0; i < NM; i++) begin
            if (m_rvalid[i] && (exp_data_q.size() == 0 || i != exp_owner)) begin
                report_error($sformatf("%s: R beat at master %0d without the grant",
                    test_name, i));
            end
            if (m_rvalid[i] && m_rready[i]) begin
                check_data(exp_data_q[0], m_rdata[i]);
                check_ctrl(exp_ctrl_q[0], m_rctrl[i]);
                if (exp_ctrl_q[0].last) begin
                    done_q.push_back(axi_read_pkg::master_t'(i + 1));
                    done_cnt[i]++;
                end
                void'(exp_data_q.pop_front());
                void'(exp_ctrl_q.pop_front());
            end
        end
        n_s = 0;
        n_m = 0;
        act = 4'd8;
        for (int j = 0; j < NS; j++) begin
            // slave beat accepted
            if (s_rvalid[j] && s_rready[j]) begin
                if (sl_beat[j] == int'(sl_ar[j].len)) begin
                    sl_busy[j] = 1'b0;
                end else begin
                    sl_beat[j]++;
                end
            end
            if (s_arvalid[j] && s_arready[j]) begin
                n_s++;
                act = axi_read_pkg::slave_t'(j);
            end
            // arvalid at a slave that no master addresses
            hit = 1'b0;
            for (int i = 0; i < NM; i++) begin
                if (m_arvalid[i] && expected_slave(m_ar[i].addr) == axi_read_pkg::slave_t'(j)) begin
                    hit = 1'b1;
                end
            end
            if (s_arvalid[j] && !hit) begin
                report_error($sformatf("%s: stray arvalid at slave %0d", test_name, j));
            end
        end
        for (int i = 0; i < NM; i++) begin
            if (m_arvalid[i] && m_arready[i]) begin
                n_m++;
                if (exp_data_q.size() != 0) begin
                    report_error($sformatf("%s: address accepted during a burst", test_name));
                end
                tgt = expected_slave(m_ar[i].addr);
                verify_target(tgt, act);
                if (act != 4'd8) begin
                    verify_ar(m_ar[i], s_ar[act]);
                end
                // beat k is addr + 4k xor slave index
                // holes give zero data with DECERR
                for (int k = 0; k <= int'(m_ar[i].len); k++) begin
                    d      = (tgt == 4'd8) ? '0 : (m_ar[i].addr + 32'(4 * k)) ^ 32'(tgt);
                    c.resp = (tgt == 4'd8) ? 2'b11 : 2'b00;
                    c.last = (k == int'(m_ar[i].len));
                    exp_data_q.push_back(d);
                    exp_ctrl_q.push_back(c);
                end
                exp_owner = i;
                void'(req_q[i].pop_front());
            end
        end
        if (n_s > 1 || (n_s == 1 && n_m == 0)) begin
            report_error($sformatf("%s: slave AR transfer with no master transfer", test_name));
        end
        // slave captures its request
        for (int j = 0; j < NS; j++) begin
            if (s_arvalid[j] && s_arready[j]) begin
                sl_busy[j] = 1'b1;
                sl_ar[j]   = s_ar[j];
                sl_beat[j] = 0;
            end
        end
    endtask

    task automatic drive_inputs();
        for (int i = 0; i < NM; i++) begin
            m_arvalid[i] = (req_q[i].size() != 0);
            if (req_q[i].size() != 0) begin
                m_ar[i] = req_q[i][0];
            end else begin
                m_ar[i] = '0;
            end
            m_rready[i] = stall_on ? ($urandom_range(0, 3) != 0) : 1'b1;
        end
        if (wv_random) begin
            m1_wvalid = ($urandom_range(0, 3) == 0);
        end
        // slaves take AR after a random delay then send one beat per cycle
        for (int j = 0; j < NS; j++) begin
            s_arready[j]     = !sl_busy[j] && ($urandom_range(0, 2) == 0);
            s_rvalid[j]      = sl_busy[j];
            s_rdata[j]       = (sl_ar[j].addr + 32'(4 * sl_beat[j])) ^ 32'(j);
            s_rctrl[j].resp  = 2'b00;
            s_rctrl[j].last  = sl_busy[j] && (sl_beat[j] == int'(sl_ar[j].len));
        end
    endtask

    task automatic step();
        sample_and_check();
        @(posedge ACLK);
        #1;
        drive_inputs();
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (req_q[0].size() + req_q[1].size() + req_q[2].size() + exp_data_q.size() != 0) begin
            if (n == limit) begin
                report_error($sformatf("%s: timeout waiting for bursts to end", test_name));
            end else begin
                step();
                n++;
            end
        end
        step();
    endtask

    task automatic wait_done(input int count, input int limit);
        int n;
        n = 0;
        while (done_q.size() < count) begin
            if (n == limit) begin
                report_error($sformatf("%s: timeout waiting for %0d bursts", test_name, count));
            end else begin
                step();
                n++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h564e_7869));
        ARESETn   = 1'b0;
        // every master requests and every slave answers while in reset
        m_ar      = '0;
        m_arvalid = '1;
        m_rready  = '1;
        m1_wvalid = 1'b0;
        s_arready = '1;
        s_rdata   = '0;
        s_rctrl   = '0;
        s_rvalid  = '1;
        stall_on  = 1'b0;
        wv_random = 1'b0;
        exp_owner = 0;
        for (int j = 0; j < NS; j++) begin
            sl_busy[j] = 1'b0;
            sl_ar[j]   = '0;
            sl_beat[j] = 0;
        end
        for (int i = 0; i < NM; i++) begin
            issued[i]   = 0;
            done_cnt[i] = 0;
        end
        test_name = "reset";
        repeat (10) begin
            @(negedge ACLK);
            check_quiet();
        end
        @(posedge ACLK);
        #1;
        ARESETn   = 1'b1;
        m_arvalid = '0;
        @(negedge ACLK);
        check_quiet();
        @(posedge ACLK);
        #1;
        m_rready  = '0;
        s_arready = '0;
        s_rvalid  = '0;
        // one burst per mapped region
        test_name = "single_region";
        for (int r = 0; r < 8; r++) begin
            issue($urandom_range(0, 2), r);
            wait_idle(500);
        end
        test_name = "unmapped";
        for (int r = 8; r < 12; r++) begin
            issue($urandom_range(0, 2), r);
            wait_idle(500);
        end
        // same-cycle requests from all masters
        test_name = "priority";
        done_q.delete();
        for (int m = 0; m < NM; m++) begin
            issue(m, $urandom_range(0, 7));
        end
        wait_idle(2000);
        check_master(axi_read_pkg::MST_M2, done_q[0]);
        check_master(axi_read_pkg::MST_M1, done_q[1]);
        check_master(axi_read_pkg::MST_M0, done_q[2]);
        // M1 held back by its pending write
        test_name = "m1_write_pending";
        done_q.delete();
        m1_wvalid = 1'b1;
        for (int m = 0; m < NM; m++) begin
            issue(m, $urandom_range(0, 11));
        end
        wait_done(2, 2000);
        m1_wvalid = 1'b0;
        wait_idle(2000);
        check_master(axi_read_pkg::MST_M2, done_q[0]);
        check_master(axi_read_pkg::MST_M0, done_q[1]);
        check_master(axi_read_pkg::MST_M1, done_q[2]);
        // random traffic with rready stalls
        test_name = "random_stalls";
        stall_on  = 1'b1;
        wv_random = 1'b1;
        repeat (6) begin
            repeat (8) begin
                issue($urandom_range(0, 2), $urandom_range(0, 11));
            end
            repeat ($urandom_range(1, 30)) begin
                step();
            end
        end
        wait_idle(20000);
        for (int i = 0; i < NM; i++) begin
            if (done_cnt[i] != issued[i]) begin
                report_error($sformatf("mismatch %s: bursts at master %0d expected %0d actual %0d",
                    test_name, i, issued[i], done_cnt[i]));
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== verilog/ar_forward.sv ====
`timescale 1ns/1ps

module ar_forward #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                                ACLK,
    input  logic                                                ARESETn,
    input  axi_read_pkg::route_t                                route,
    input  axi_read_pkg::ar_req_t [axi_read_pkg::NUM_MASTERS-1:0] m_ar,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0]                m_arvalid,
    output logic [axi_read_pkg::NUM_MASTERS-1:0]                m_arready,
    output axi_read_pkg::ar_req_t [axi_read_pkg::NUM_SLAVES-1:0]  s_ar,
    output logic [axi_read_pkg::NUM_SLAVES-1:0]                 s_arvalid,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0]                 s_arready,
    output axi_read_pkg::ar_req_t                               err_ar,
    output logic                                                err_arvalid,
    input  logic                                                err_arready
);

    logic [axi_read_pkg::NUM_MASTERS-1:0] gnt;
    axi_read_pkg::ar_req_t                sel_ar;
    logic                                 sel_valid;
    logic                                 tgt_ready;
    logic                                 req;
    logic                                 sent;

    // bus must carry whole bytes
    if (DATA_WIDTH % 8 != 0) begin : g_width_check
        $error("DATA_WIDTH is not a multiple of 8");
    end

    assign gnt = axi_read_pkg::grant_onehot(route.mst);

    always_comb begin
        // pick granted master's request
        sel_ar    = '0;
        sel_valid = 1'b0;
        for (int i = 0; i < axi_read_pkg::NUM_MASTERS; i++) begin
            if (gnt[i]) begin
                sel_ar    = m_ar[i];
                sel_valid = m_arvalid[i];
            end
        end
        // one address per grant
        req = sel_valid && !sent;
        // fan out to the routed target only
        s_ar      = '0;
        s_arvalid = '0;
        tgt_ready = err_arready;
        for (int j = 0; j < axi_read_pkg::NUM_SLAVES; j++) begin
            if (route.slv == axi_read_pkg::slave_t'(j)) begin
                s_ar[j]      = sel_ar;
                s_arvalid[j] = req;
                tgt_ready    = s_arready[j];
            end
        end
        err_ar      = sel_ar;
        err_arvalid = req && (route.slv == axi_read_pkg::SLV_NONE);
        // ready back to the owner only
        m_arready = gnt & {axi_read_pkg::NUM_MASTERS{tgt_ready && !sent}};
    end

    // set at the AR transfer, cleared in the idle gap
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            sent <= 1'b0;
        end else if (route.mst == axi_read_pkg::MST_NONE) begin
            sent <= 1'b0;
        end else if (req && tgt_ready) begin
            sent <= 1'b1;
        end
    end

    a_one_target: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $onehot0({err_arvalid, s_arvalid}))
        else $error("more than one AR target selected");

endmodule

// ==== verilog/axi_read_pkg.sv ====
package axi_read_pkg;

    // byte address on the AR channel
    typedef logic [31:0] addr_t;

    // burst length, beats = len + 1
    typedef logic [3:0] len_t;

    // read response codes
    typedef logic [1:0] resp_t;
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // granted master, doubles as arbiter state
    typedef enum logic [1:0] {
        MST_NONE,
        MST_M0,
        MST_M1,
        MST_M2
    } master_t;

    // slave index in address map order
    typedef logic [3:0] slave_t;
    localparam slave_t SLV_ROM   = 4'd0;
    localparam slave_t SLV_IM    = 4'd1;
    localparam slave_t SLV_DM    = 4'd2;
    localparam slave_t SLV_SCTRL = 4'd3;
    localparam slave_t SLV_WDT   = 4'd4;
    localparam slave_t SLV_DRAM  = 4'd5;
    localparam slave_t SLV_EPU   = 4'd6;
    localparam slave_t SLV_DMA   = 4'd7;
    // unmapped, goes to the error responder
    localparam slave_t SLV_NONE  = 4'd8;

    localparam int NUM_MASTERS = 3;
    localparam int NUM_SLAVES  = 8;

    // region match values
    // most regions compare address bits 31:16
    // DRAM compares only bits 31:24
    localparam logic [15:0] REGION_ROM   = 16'h0000;
    localparam logic [15:0] REGION_IM    = 16'h0001;
    localparam logic [15:0] REGION_DM    = 16'h0002;
    localparam logic [15:0] REGION_SCTRL = 16'h1000;
    localparam logic [15:0] REGION_WDT   = 16'h1001;
    localparam logic [7:0]  REGION_DRAM  = 8'h20;
    localparam logic [15:0] REGION_EPU   = 16'h0010;
    localparam logic [15:0] REGION_DMA   = 16'h0003;
    // any other address decodes to SLV_NONE

    typedef struct packed {
        addr_t addr;
        len_t  len;
    } ar_req_t;

    typedef struct packed {
        resp_t resp;
        logic  last;
    } r_ctrl_t;

    // active whenever mst is not MST_NONE
    typedef struct packed {
        master_t mst;
        slave_t  slv;
    } route_t;

    // one bit per master port, zero when idle
    function automatic logic [NUM_MASTERS-1:0] grant_onehot(input master_t mst);
        logic [NUM_MASTERS-1:0] gnt;
        gnt = '0;
        case (mst)
            MST_M0:  gnt[0] = 1'b1;
            MST_M1:  gnt[1] = 1'b1;
            MST_M2:  gnt[2] = 1'b1;
            default: gnt = '0;
        endcase
        return gnt;
    endfunction

endpackage

// ==== verilog/decode_error_slave.sv ====
`timescale 1ns/1ps

module decode_error_slave #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  ACLK,
    input  logic                  ARESETn,
    input  axi_read_pkg::ar_req_t ar,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [DATA_WIDTH-1:0] rdata,
    output axi_read_pkg::r_ctrl_t rctrl,
    output logic                  rvalid,
    input  logic                  rready
);

    typedef enum logic {
        ERR_IDLE,
        ERR_RESP
    } err_state_t;

    err_state_t         state;
    axi_read_pkg::len_t len_q;
    axi_read_pkg::len_t beat;
    logic               last_beat;

    // address accepted whenever idle
    assign arready   = (state == ERR_IDLE);
    assign rvalid    = (state == ERR_RESP);
    assign last_beat = rvalid && (beat == len_q);

    // zero data, DECERR on every beat
    assign rdata      = '0;
    assign rctrl.resp = axi_read_pkg::RESP_DECERR;
    assign rctrl.last = last_beat;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state <= ERR_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                ERR_IDLE: begin
                    if (arvalid) begin
                        state <= ERR_RESP;
                        beat  <= '0;
                    end
                end
                ERR_RESP: begin
                    // one beat per accepted rready
                    if (rready) begin
                        if (last_beat) begin
                            state <= ERR_IDLE;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                default: state <= ERR_IDLE;
            endcase
        end
    end

    // length captured with the AR transfer
    always_ff @(posedge ACLK) begin
        if (arvalid && arready) begin
            len_q <= ar.len;
        end
    end

endmodule

// ==== verilog/r_return.sv ====
`timescale 1ns/1ps

module r_return #(
    parameter int DATA_WIDTH = 32
) (
    input  axi_read_pkg::route_t                                     route,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0][DATA_WIDTH-1:0]      s_rdata,
    input  axi_read_pkg::r_ctrl_t [axi_read_pkg::NUM_SLAVES-1:0]     s_rctrl,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0]                      s_rvalid,
    output logic [axi_read_pkg::NUM_SLAVES-1:0]                      s_rready,
    input  logic [DATA_WIDTH-1:0]                                    err_rdata,
    input  axi_read_pkg::r_ctrl_t                                    err_rctrl,
    input  logic                                                     err_rvalid,
    output logic                                                     err_rready,
    output logic [axi_read_pkg::NUM_MASTERS-1:0][DATA_WIDTH-1:0]     m_rdata,
    output axi_read_pkg::r_ctrl_t [axi_read_pkg::NUM_MASTERS-1:0]    m_rctrl,
    output logic [axi_read_pkg::NUM_MASTERS-1:0]                     m_rvalid,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0]                     m_rready,
    output logic                                                     burst_done
);

    logic [axi_read_pkg::NUM_MASTERS-1:0] gnt;
    logic [DATA_WIDTH-1:0]                sel_data;
    axi_read_pkg::r_ctrl_t                sel_ctrl;
    logic                                 sel_valid;
    logic                                 sel_ready;
    logic                                 is_err;

    assign gnt    = axi_read_pkg::grant_onehot(route.mst);
    assign is_err = (route.slv == axi_read_pkg::SLV_NONE);

    always_comb begin
        // source side, error responder unless a slave matches
        sel_data  = err_rdata;
        sel_ctrl  = err_rctrl;
        sel_valid = err_rvalid;
        for (int j = 0; j < axi_read_pkg::NUM_SLAVES; j++) begin
            if (route.slv == axi_read_pkg::slave_t'(j)) begin
                sel_data  = s_rdata[j];
                sel_ctrl  = s_rctrl[j];
                sel_valid = s_rvalid[j];
            end
        end
        // owner's rready, zero when idle
        sel_ready = |(gnt & m_rready);
        // other masters see nothing
        for (int i = 0; i < axi_read_pkg::NUM_MASTERS; i++) begin
            m_rdata[i]  = gnt[i] ? sel_data : '0;
            m_rctrl[i]  = gnt[i] ? sel_ctrl : '0;
            m_rvalid[i] = gnt[i] && sel_valid;
        end
        // back-pressure straight to the source
        for (int j = 0; j < axi_read_pkg::NUM_SLAVES; j++) begin
            s_rready[j] = (route.slv == axi_read_pkg::slave_t'(j)) && sel_ready;
        end
        err_rready = is_err && sel_ready;
    end

    // last beat accepted by the granted master
    assign burst_done = sel_valid && sel_ready && sel_ctrl.last;

    // slave data must never be consumed with no grant
    always_comb begin
        if (route.mst == axi_read_pkg::MST_NONE) begin
            a_no_stray_beat: assert (!(|(s_rvalid & s_rready)))
                else $error("slave R beat accepted with no active route");
        end
    end

endmodule

// ==== verilog/read_arbiter.sv ====
`timescale 1ns/1ps

module read_arbiter (
    input  logic                                                ACLK,
    input  logic                                                ARESETn,
    input  axi_read_pkg::ar_req_t [axi_read_pkg::NUM_MASTERS-1:0] m_ar,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0]                m_arvalid,
    input  logic                                                m1_wvalid,
    input  logic                                                burst_done,
    output axi_read_pkg::route_t                                route
);

    axi_read_pkg::master_t state;
    axi_read_pkg::master_t next_mst;
    axi_read_pkg::addr_t   next_addr;
    axi_read_pkg::addr_t   addr_q;
    axi_read_pkg::slave_t  dec_slv;

    // fixed priority pick, M2 first
    // M1 waits while its write data is pending
    always_comb begin
        next_mst  = axi_read_pkg::MST_NONE;
        next_addr = m_ar[0].addr;
        if (m_arvalid[2]) begin
            next_mst  = axi_read_pkg::MST_M2;
            next_addr = m_ar[2].addr;
        end else if (m_arvalid[1] && !m1_wvalid) begin
            next_mst  = axi_read_pkg::MST_M1;
            next_addr = m_ar[1].addr;
        end else if (m_arvalid[0]) begin
            next_mst  = axi_read_pkg::MST_M0;
            next_addr = m_ar[0].addr;
        end
    end

    // grant held until the last beat is accepted
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state <= axi_read_pkg::MST_NONE;
        end else if (state == axi_read_pkg::MST_NONE) begin
            state <= next_mst;
        end else if (burst_done) begin
            state <= axi_read_pkg::MST_NONE;
        end
    end

    // address sampled on every idle edge, so it is
    // the granted one once the grant takes effect
    always_ff @(posedge ACLK) begin
        if (state == axi_read_pkg::MST_NONE) begin
            addr_q <= next_addr;
        end
    end

    // address map
    always_comb begin
        if (addr_q[31:16] == axi_read_pkg::REGION_ROM) begin
            dec_slv = axi_read_pkg::SLV_ROM;
        end else if (addr_q[31:16] == axi_read_pkg::REGION_IM) begin
            dec_slv = axi_read_pkg::SLV_IM;
        end else if (addr_q[31:16] == axi_read_pkg::REGION_DM) begin
            dec_slv = axi_read_pkg::SLV_DM;
        end else if (addr_q[31:16] == axi_read_pkg::REGION_SCTRL) begin
            dec_slv = axi_read_pkg::SLV_SCTRL;
        end else if (addr_q[31:16] == axi_read_pkg::REGION_WDT) begin
            dec_slv = axi_read_pkg::SLV_WDT;
        end else if (addr_q[31:24] == axi_read_pkg::REGION_DRAM) begin
            dec_slv = axi_read_pkg::SLV_DRAM;
        end else if (addr_q[31:16] == axi_read_pkg::REGION_EPU) begin
            dec_slv = axi_read_pkg::SLV_EPU;
        end else if (addr_q[31:16] == axi_read_pkg::REGION_DMA) begin
            dec_slv = axi_read_pkg::SLV_DMA;
        end else begin
            dec_slv = axi_read_pkg::SLV_NONE;
        end
    end

    // slave field only meaningful while granted
    always_comb begin
        route.mst = state;
        if (state == axi_read_pkg::MST_NONE) begin
            route.slv = axi_read_pkg::SLV_NONE;
        end else begin
            route.slv = dec_slv;
        end
    end

    // route frozen for the whole burst
    a_route_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (route.mst != axi_read_pkg::MST_NONE && !burst_done) |=> $stable(route))
        else $error("route changed during a burst");

    // last beat from r_return only under a grant
    a_done_active: assert property (@(posedge ACLK) disable iff (!ARESETn)
        burst_done |-> route.mst != axi_read_pkg::MST_NONE)
        else $error("burst_done without an active route");

endmodule

// ==== verilog/read_interconnect.sv ====
`timescale 1ns/1ps

module read_interconnect #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                                  ACLK,
    input  logic                                                  ARESETn,
    // master side
    input  axi_read_pkg::ar_req_t [axi_read_pkg::NUM_MASTERS-1:0]  m_ar,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0]                  m_arvalid,
    output logic [axi_read_pkg::NUM_MASTERS-1:0]                  m_arready,
    output logic [axi_read_pkg::NUM_MASTERS-1:0][DATA_WIDTH-1:0]  m_rdata,
    output axi_read_pkg::r_ctrl_t [axi_read_pkg::NUM_MASTERS-1:0] m_rctrl,
    output logic [axi_read_pkg::NUM_MASTERS-1:0]                  m_rvalid,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0]                  m_rready,
    input  logic                                                  m1_wvalid,
    // slave side
    output axi_read_pkg::ar_req_t [axi_read_pkg::NUM_SLAVES-1:0]   s_ar,
    output logic [axi_read_pkg::NUM_SLAVES-1:0]                   s_arvalid,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0]                   s_arready,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0][DATA_WIDTH-1:0]   s_rdata,
    input  axi_read_pkg::r_ctrl_t [axi_read_pkg::NUM_SLAVES-1:0]  s_rctrl,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0]                   s_rvalid,
    output logic [axi_read_pkg::NUM_SLAVES-1:0]                   s_rready
);

    axi_read_pkg::route_t  route;
    logic                  burst_done;
    // error responder channels
    axi_read_pkg::ar_req_t err_ar;
    logic                  err_arvalid;
    logic                  err_arready;
    logic [DATA_WIDTH-1:0] err_rdata;
    axi_read_pkg::r_ctrl_t err_rctrl;
    logic                  err_rvalid;
    logic                  err_rready;

    read_arbiter i_read_arbiter (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .m_ar       (m_ar),
        .m_arvalid  (m_arvalid),
        .m1_wvalid  (m1_wvalid),
        .burst_done (burst_done),
        .route      (route)
    );

    ar_forward #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_ar_forward (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .route       (route),
        .m_ar        (m_ar),
        .m_arvalid   (m_arvalid),
        .m_arready   (m_arready),
        .s_ar        (s_ar),
        .s_arvalid   (s_arvalid),
        .s_arready   (s_arready),
        .err_ar      (err_ar),
        .err_arvalid (err_arvalid),
        .err_arready (err_arready)
    );

    r_return #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_r_return (
        .route      (route),
        .s_rdata    (s_rdata),
        .s_rctrl    (s_rctrl),
        .s_rvalid   (s_rvalid),
        .s_rready   (s_rready),
        .err_rdata  (err_rdata),
        .err_rctrl  (err_rctrl),
        .err_rvalid (err_rvalid),
        .err_rready (err_rready),
        .m_rdata    (m_rdata),
        .m_rctrl    (m_rctrl),
        .m_rvalid   (m_rvalid),
        .m_rready   (m_rready),
        .burst_done (burst_done)
    );

    decode_error_slave #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_decode_error_slave (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .ar      (err_ar),
        .arvalid (err_arvalid),
        .arready (err_arready),
        .rdata   (err_rdata),
        .rctrl   (err_rctrl),
        .rvalid  (err_rvalid),
        .rready  (err_rready)
    );

endmodule
